// ==== cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ========================================
// Core pipeline geometry
// ========================================

// Issue slots per cycle. The issue logic handles two only.
`define ISSUE_NUM 2

// Data-cache stages that follow execute.
`define DCACHE_PIPE_DEPTH 2

`endif

// ==== cpu_pkg.sv ====
package cpu_pkg;

// ========================================
// Basic types
// ========================================

typedef logic [31:0] uint32_t;
typedef logic [4:0]  reg_addr_t;

// ========================================
// Decoded operations
// ========================================

typedef enum logic [4:0] {
	OP_NOP = 5'd0,           // Must stay zero, bubbles rely on it.
	OP_ADDU,
	OP_SUBU,
	OP_AND,
	OP_OR,
	OP_SLT,
	OP_ADDIU,
	OP_ORI,
	OP_LUI,
	OP_LW,
	OP_SW,
	OP_LL,
	OP_SC,
	OP_MULT,
	OP_MFHI,
	OP_MFLO,
	OP_MFC0,
	OP_MTC0,
	OP_ERET
} op_t;

// ========================================
// Pipeline payloads
// ========================================

typedef struct packed {
	logic    valid;
	uint32_t pc;
	uint32_t instr;
} fetch_entry_t;

typedef struct packed {
	op_t       op;
	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;
	logic      is_load;
	logic      is_store;
	logic      is_priv;
	logic      is_nonrw_priv;  // ERET and similar, must run alone.
} decoded_instr_t;

endpackage

// ==== instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder(
	input  cpu_pkg::fetch_entry_t   entry,
	output cpu_pkg::decoded_instr_t decoded
);

import cpu_pkg::*;

logic [5:0] opcode, funct;
reg_addr_t  rs, rt, rd;

assign opcode = entry.instr[31:26];
assign funct  = entry.instr[5:0];
assign rs     = entry.instr[25:21];
assign rt     = entry.instr[20:16];
assign rd     = entry.instr[15:11];

always_comb begin
	decoded = '0;
	if (entry.valid) begin
		case (opcode)
			6'b000000: begin // SPECIAL.
				case (funct)
					6'b100001: decoded.op = OP_ADDU;
					6'b100011: decoded.op = OP_SUBU;
					6'b100100: decoded.op = OP_AND;
					6'b100101: decoded.op = OP_OR;
					6'b101010: decoded.op = OP_SLT;
					6'b011000: decoded.op = OP_MULT;
					6'b010000: decoded.op = OP_MFHI;
					6'b010010: decoded.op = OP_MFLO;
					default:   decoded.op = OP_NOP;
				endcase
				if (decoded.op == OP_MFHI || decoded.op == OP_MFLO) begin
					decoded.rd = rd;
				end else if (decoded.op != OP_NOP) begin
					decoded.rs1 = rs;
					decoded.rs2 = rt;
					decoded.rd  = (decoded.op == OP_MULT) ? 5'd0 : rd;
				end
			end
			6'b001001, 6'b001101, 6'b001111, 6'b100011, 6'b110000: begin
				case (opcode)
					6'b001001: decoded.op = OP_ADDIU;
					6'b001101: decoded.op = OP_ORI;
					6'b001111: decoded.op = OP_LUI;
					6'b100011: decoded.op = OP_LW;
					default:   decoded.op = OP_LL;
				endcase
				decoded.rs1     = rs;
				decoded.rd      = rt;
				decoded.is_load = (opcode == 6'b100011) || (opcode == 6'b110000);
			end
			6'b101011: begin
				decoded.op       = OP_SW;
				decoded.rs1      = rs;
				decoded.rs2      = rt;
				decoded.is_store = 1'b1;
			end
			6'b111000: begin
				decoded.op       = OP_SC;  // Reads, stores, then writes the flag.
				decoded.rs1      = rs;
				decoded.rs2      = rt;
				decoded.rd       = rt;
				decoded.is_load  = 1'b1;
				decoded.is_store = 1'b1;
			end
			6'b010000: begin // COP0.
				if (entry.instr[25] && funct == 6'b011000) begin
					decoded.op            = OP_ERET;
					decoded.is_priv       = 1'b1;
					decoded.is_nonrw_priv = 1'b1;
				end else if (rs == 5'b00000) begin
					decoded.op      = OP_MFC0;
					decoded.rd      = rt;
					decoded.is_priv = 1'b1;
				end else if (rs == 5'b00100) begin
					decoded.op      = OP_MTC0;
					decoded.rs1     = rt;
					decoded.is_priv = 1'b1;
				end
			end
			default: decoded.op = OP_NOP;
		endcase
	end
end

endmodule

// ==== instr_issue.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module instr_issue(
	input  cpu_pkg::fetch_entry_t   [`ISSUE_NUM-1:0] fetch_entry,
	input  cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0] id_decoded,
	input  cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0] ex_decoded,
	input  cpu_pkg::decoded_instr_t [`DCACHE_PIPE_DEPTH-1:0][`ISSUE_NUM-1:0] dcache_decoded,
	input  logic                                     delayslot_not_exec,
	output cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0] issue_instr,
	output logic [$clog2(`ISSUE_NUM+1)-1:0]          issue_num,
	output logic                                     stall_req
);

import cpu_pkg::*;

// ========================================
// Hazard helpers
// ========================================

// Raw HI/LO users, MADD family included.
function automatic logic uses_hilo(input uint32_t instr);
	return (instr[31:26] == 6'b000000 && instr[5:4] == 2'b01 && instr[2] == 1'b0)
		|| (instr[31:26] == 6'b011100 && instr[5:3] == 3'b000 && instr[1] == 1'b0);
endfunction

function automatic logic reads_reg(input decoded_instr_t consumer, input reg_addr_t dst);
	return dst != '0 && (consumer.rs1 == dst || consumer.rs2 == dst);
endfunction

logic                  slot1_dropped;
logic                  priv_in_flight, nonrw_in_flight;
logic [`ISSUE_NUM-1:0] valid, ssnop, mem_access, hilo_access, load_related;

for (genvar i = 0; i < `ISSUE_NUM; i++) begin : gen_slot
	assign valid[i]       = fetch_entry[i].valid;
	assign ssnop[i]       = fetch_entry[i].valid && fetch_entry[i].instr == 32'h40;
	assign mem_access[i]  = id_decoded[i].is_load | id_decoded[i].is_store;
	assign hilo_access[i] = uses_hilo(fetch_entry[i].instr);
end

// ========================================
// Load-use and privilege tracking
// ========================================

always_comb begin
	load_related = '0;
	for (int i = 0; i < `ISSUE_NUM; i++) begin
		for (int j = 0; j < `ISSUE_NUM; j++) begin
			if (ex_decoded[j].is_load && reads_reg(id_decoded[i], ex_decoded[j].rd))
				load_related[i] = 1'b1;
			// The last dcache stage forwards, so it is skipped.
			for (int k = 0; k < `DCACHE_PIPE_DEPTH - 1; k++) begin
				if (dcache_decoded[k][j].is_load
						&& reads_reg(id_decoded[i], dcache_decoded[k][j].rd))
					load_related[i] = 1'b1;
			end
		end
	end
	load_related &= valid;
end

always_comb begin
	priv_in_flight  = 1'b0;
	nonrw_in_flight = 1'b0;
	for (int j = 0; j < `ISSUE_NUM; j++) begin
		priv_in_flight  |= ex_decoded[j].is_priv;
		nonrw_in_flight |= ex_decoded[j].is_nonrw_priv;
		for (int k = 0; k < `DCACHE_PIPE_DEPTH; k++) begin
			priv_in_flight  |= dcache_decoded[k][j].is_priv;
			nonrw_in_flight |= dcache_decoded[k][j].is_nonrw_priv;
		end
	end
end

// ========================================
// Issue decision
// ========================================

assign slot1_dropped = ~valid[1]
	| reads_reg(id_decoded[1], id_decoded[0].rd)
	| (mem_access[0] & mem_access[1])
	| (hilo_access[0] & hilo_access[1])
	| delayslot_not_exec                              // Delay slot squashed.
	| (|ssnop)
	| (id_decoded[0].op == OP_SC) | (id_decoded[1].op == OP_SC)
	| id_decoded[0].is_priv | id_decoded[1].is_priv;

assign stall_req = load_related[0]
	| (load_related[1] & ~slot1_dropped)
	| (id_decoded[0].is_nonrw_priv & priv_in_flight)
	| nonrw_in_flight
	| (valid == '0);                                 // Nothing to issue.

always_comb begin
	issue_instr = id_decoded;
	issue_num   = 2;
	if (slot1_dropped) begin
		issue_instr[1] = '0;
		issue_num      = 1;
	end
end

endmodule

// ==== exec_pipe_tracker.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module exec_pipe_tracker(
	input  logic                                     clk,
	input  logic                                     rst,
	input  cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0] issue_instr,
	input  logic                                     stall_req,
	output cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0] ex_decoded,
	output cpu_pkg::decoded_instr_t [`DCACHE_PIPE_DEPTH-1:0][`ISSUE_NUM-1:0] dcache_decoded
);

import cpu_pkg::*;

decoded_instr_t [`ISSUE_NUM-1:0] ex_next;

// A stall inserts a bubble pair into execute.
assign ex_next = stall_req ? '0 : issue_instr;

// ========================================
// Execute stage
// ========================================

always_ff @(posedge clk) begin
	if (rst) begin
		ex_decoded <= '0;
	end else begin
		ex_decoded <= ex_next;
	end
end

// ========================================
// Data-cache stages
// ========================================

// No downstream stall, these always shift.
always_ff @(posedge clk) begin
	if (rst) begin
		dcache_decoded <= '0;
	end else begin
		dcache_decoded[0] <= ex_decoded;
		for (int k = 1; k < `DCACHE_PIPE_DEPTH; k++) begin
			dcache_decoded[k] <= dcache_decoded[k-1];
		end
	end
end

endmodule

// ==== issue_stage.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module issue_stage(
	input  logic                                     clk,
	input  logic                                     rst,
	input  cpu_pkg::fetch_entry_t   [`ISSUE_NUM-1:0] fetch_entry,
	input  logic                                     delayslot_not_exec,
	output cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0] issue_instr,
	output logic [$clog2(`ISSUE_NUM+1)-1:0]          issue_num,
	output logic                                     stall_req
);

import cpu_pkg::*;

decoded_instr_t [`ISSUE_NUM-1:0] id_decoded;
decoded_instr_t [`ISSUE_NUM-1:0] ex_decoded;
decoded_instr_t [`DCACHE_PIPE_DEPTH-1:0][`ISSUE_NUM-1:0] dcache_decoded;

for (genvar i = 0; i < `ISSUE_NUM; i++) begin : gen_decoder
	instr_decoder i_decoder (
		.entry   (fetch_entry[i]),
		.decoded (id_decoded[i])
	);
end

instr_issue i_issue (
	.fetch_entry        (fetch_entry),
	.id_decoded         (id_decoded),
	.ex_decoded         (ex_decoded),
	.dcache_decoded     (dcache_decoded),
	.delayslot_not_exec (delayslot_not_exec),
	.issue_instr        (issue_instr),
	.issue_num          (issue_num),
	.stall_req          (stall_req)
);

// Mirrors what has left issue, for the hazard checks.
exec_pipe_tracker i_tracker (
	.clk            (clk),
	.rst            (rst),
	.issue_instr    (issue_instr),
	.stall_req      (stall_req),
	.ex_decoded     (ex_decoded),
	.dcache_decoded (dcache_decoded)
);

endmodule

// ==== issue_stage_checker.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module issue_stage_checker(
	input logic                                     clk,
	input logic                                     rst,
	input cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0] issue_instr,
	input logic [$clog2(`ISSUE_NUM+1)-1:0]          issue_num,
	input cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0] ex_decoded,
	input cpu_pkg::decoded_instr_t [`DCACHE_PIPE_DEPTH-1:0][`ISSUE_NUM-1:0] dcache_decoded
);

import cpu_pkg::*;

logic priv_in_flight;
logic eret_in_ex;

always_comb begin
	priv_in_flight = 1'b0;
	eret_in_ex = 1'b0;
	for (int j = 0; j < `ISSUE_NUM; j++) begin
		priv_in_flight |= ex_decoded[j].is_priv;
		eret_in_ex |= ex_decoded[j].op == OP_ERET;
		for (int k = 0; k < `DCACHE_PIPE_DEPTH; k++)
			priv_in_flight |= dcache_decoded[k][j].is_priv;
	end
end

issue_count_legal: assert property (@(posedge clk) disable iff (rst)
	issue_num == 1 || issue_num == 2)
	else $error("issue_num out of range: %0d", issue_num);

dropped_slot_zero: assert property (@(posedge clk) disable iff (rst)
	issue_num == 1 |-> issue_instr[1] == '0)
	else $error("slot 1 not zeroed when only one instruction issues");

eret_runs_alone: assert property (@(posedge clk) disable iff (rst)
	priv_in_flight |=> !eret_in_ex)
	else $error("ERET entered execute behind a privileged instruction");

endmodule

bind issue_stage issue_stage_checker i_checker (.*);

// ==== issue_stage_tb.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module issue_stage_tb;

import cpu_pkg::*;

localparam int RANDOM_CYCLES = 2000;
localparam int DIRECTED_CYCLES = 60;
localparam int K_ADDU = 0, K_LW = 8, K_SW = 9, K_SC = 11, K_MULT = 12, K_MFHI = 13;
localparam int K_MFLO = 14, K_MFC0 = 15, K_MTC0 = 16, K_ERET = 17, K_SSNOP = 18;

// Base encodings with register fields clear, listed from SSNOP down to ADDU.
localparam logic [18:0][31:0] TEMPLATES = {
	32'h00000040, 32'h42000018, 32'h40800000, 32'h40000000, 32'h00000012,
	32'h00000010, 32'h00000018, 32'he0000000, 32'hc0000000, 32'hac000000,
	32'h8c000000, 32'h3c000000, 32'h34000000, 32'h24000000, 32'h0000002a,
	32'h00000025, 32'h00000024, 32'h00000023, 32'h00000021
};

logic                            clk = 1'b0;
logic                            rst;
logic                            delayslot_not_exec;
fetch_entry_t   [`ISSUE_NUM-1:0] fetch_entry;
decoded_instr_t [`ISSUE_NUM-1:0] issue_instr;
logic [$clog2(`ISSUE_NUM+1)-1:0] issue_num;
logic                            stall_req;

// Model state and the expected outputs of the current cycle.
decoded_instr_t [`ISSUE_NUM-1:0] ex_m, exp_instr;
decoded_instr_t [`DCACHE_PIPE_DEPTH-1:0][`ISSUE_NUM-1:0] dc_m;
logic [1:0] exp_num;
logic       exp_stall;
integer     seed = 32'hc63a;
int         errors = 0;
int         test_errors = 0;
uint32_t    pc = '0;

always #50 clk = ~clk;

issue_stage i_dut (.*);

// ========================================
// Reference model
// ========================================

function automatic decoded_instr_t ref_decode(input fetch_entry_t e);
	reg_addr_t rs, rt, rd;
	rs = e.instr[25:21];
	rt = e.instr[20:16];
	rd = e.instr[15:11];
	if (!e.valid)
		return '0;
	casez (e.instr)
		{6'h00, 20'b?, 6'h21}: return {OP_ADDU, rs, rt, rd, 4'b0000};
		{6'h00, 20'b?, 6'h23}: return {OP_SUBU, rs, rt, rd, 4'b0000};
		{6'h00, 20'b?, 6'h24}: return {OP_AND, rs, rt, rd, 4'b0000};
		{6'h00, 20'b?, 6'h25}: return {OP_OR, rs, rt, rd, 4'b0000};
		{6'h00, 20'b?, 6'h2a}: return {OP_SLT, rs, rt, rd, 4'b0000};
		{6'h00, 20'b?, 6'h18}: return {OP_MULT, rs, rt, 5'd0, 4'b0000};
		{6'h00, 20'b?, 6'h10}: return {OP_MFHI, 10'd0, rd, 4'b0000};
		{6'h00, 20'b?, 6'h12}: return {OP_MFLO, 10'd0, rd, 4'b0000};
		{6'h09, 26'b?}:        return {OP_ADDIU, rs, 5'd0, rt, 4'b0000};
		{6'h0d, 26'b?}:        return {OP_ORI, rs, 5'd0, rt, 4'b0000};
		{6'h0f, 26'b?}:        return {OP_LUI, rs, 5'd0, rt, 4'b0000};
		{6'h23, 26'b?}:        return {OP_LW, rs, 5'd0, rt, 4'b1000};
		{6'h30, 26'b?}:        return {OP_LL, rs, 5'd0, rt, 4'b1000};
		{6'h2b, 26'b?}:        return {OP_SW, rs, rt, 5'd0, 4'b0100};
		{6'h38, 26'b?}:        return {OP_SC, rs, rt, rt, 4'b1100};
		32'h42000018:          return {OP_ERET, 15'd0, 4'b0011};
		{6'h10, 5'h00, 21'b?}: return {OP_MFC0, 10'd0, rt, 4'b0010};
		{6'h10, 5'h04, 21'b?}: return {OP_MTC0, rt, 10'd0, 4'b0010};
		default:               return '0;
	endcase
endfunction

function automatic logic uses_hi_lo(input uint32_t w);
	return w[31:26] == 6'h00 && (w[5:0] == 6'h10 || w[5:0] == 6'h12 || w[5:0] == 6'h18);
endfunction

function automatic logic depends_on(input decoded_instr_t d, input reg_addr_t r);
	return r != 5'd0 && (d.rs1 == r || d.rs2 == r);
endfunction

function automatic logic load_use(input decoded_instr_t d);
	logic hit;
	hit = 1'b0;
	for (int j = 0; j < `ISSUE_NUM; j++) begin
		hit |= ex_m[j].is_load && depends_on(d, ex_m[j].rd);
		for (int k = 0; k < `DCACHE_PIPE_DEPTH - 1; k++)
			hit |= dc_m[k][j].is_load && depends_on(d, dc_m[k][j].rd);
	end
	return hit;
endfunction

task automatic model_eval();
	decoded_instr_t d0, d1;
	logic drop, priv_fl, nonrw_fl;
	d0 = ref_decode(fetch_entry[0]);
	d1 = ref_decode(fetch_entry[1]);
	priv_fl = 1'b0;
	nonrw_fl = 1'b0;
	for (int j = 0; j < `ISSUE_NUM; j++) begin
		priv_fl |= ex_m[j].is_priv;
		nonrw_fl |= ex_m[j].is_nonrw_priv;
		for (int k = 0; k < `DCACHE_PIPE_DEPTH; k++) begin
			priv_fl |= dc_m[k][j].is_priv;
			nonrw_fl |= dc_m[k][j].is_nonrw_priv;
		end
	end
	drop = !fetch_entry[1].valid || depends_on(d1, d0.rd) || delayslot_not_exec
		|| ((d0.is_load || d0.is_store) && (d1.is_load || d1.is_store))
		|| (uses_hi_lo(fetch_entry[0].instr) && uses_hi_lo(fetch_entry[1].instr))
		|| (fetch_entry[0].valid && fetch_entry[0].instr == TEMPLATES[K_SSNOP])
		|| (fetch_entry[1].valid && fetch_entry[1].instr == TEMPLATES[K_SSNOP])
		|| d0.op == OP_SC || d1.op == OP_SC || d0.is_priv || d1.is_priv;
	exp_instr[0] = d0;
	exp_instr[1] = drop ? '0 : d1;
	exp_num = drop ? 2'd1 : 2'd2;
	exp_stall = load_use(d0) || (load_use(d1) && !drop) || (d0.is_nonrw_priv && priv_fl)
		|| nonrw_fl || (!fetch_entry[0].valid && !fetch_entry[1].valid);
endtask

// ========================================
// Stimulus and checks
// ========================================

function automatic uint32_t enc(input int k, input reg_addr_t rs, input reg_addr_t rt,
		input reg_addr_t rd);
	uint32_t w;
	w = TEMPLATES[k];
	if (k <= K_MFLO)
		w[25:21] = rs;
	if (k <= K_MTC0) begin
		w[20:16] = rt;
		w[15:11] = rd;
	end
	return w;
endfunction

function automatic uint32_t rand_instr();
	return enc({$random(seed)} % 19, $random(seed) & 3, $random(seed) & 3, $random(seed) & 3);
endfunction

task automatic check_value(input string name, input logic [47:0] got, input logic [47:0] exp);
	if (got !== exp) begin
		$display("CHECK FAILED: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		errors++;
	end
endtask

task automatic drive(input logic v0, input uint32_t i0, input logic v1, input uint32_t i1,
		input logic dsne);
	fetch_entry[0] = {v0, pc, i0};
	fetch_entry[1] = {v1, pc + 32'd4, i1};
	delayslot_not_exec = dsne;
	pc += 32'd8;
endtask

task automatic sample();
	#40;                                              // Just before the rising edge.
	model_eval();
	check_value("issue_instr[0]", issue_instr[0], exp_instr[0]);
	check_value("issue_instr[1]", issue_instr[1], exp_instr[1]);
	check_value("issue_num", issue_num, exp_num);
	check_value("stall_req", stall_req, exp_stall);
endtask

task automatic advance();
	@(posedge clk);
	for (int k = `DCACHE_PIPE_DEPTH - 1; k > 0; k--)
		dc_m[k] = dc_m[k-1];
	dc_m[0] = ex_m;
	ex_m = exp_stall ? '0 : exp_instr;
	@(negedge clk);
endtask

// Holds the current pair and expects n stalled cycles before it issues.
task automatic expect_stalls(input int n);
	for (int t = 0; t <= n; t++) begin
		sample();
		check_value("stall_req", stall_req, t < n);
		advance();
	end
endtask

task automatic flush();
	drive(1'b0, 32'h0, 1'b0, 32'h0, 1'b0);
	repeat (`DCACHE_PIPE_DEPTH + 1) begin
		sample();
		advance();
	end
endtask

task automatic finish_test(input int num, input string name);
	$display("Test %0d %s finished with %0d errors", num, name, errors - test_errors);
	test_errors = errors;
endtask

initial begin
	rst = 1'b1;
	drive(1'b0, 32'h0, 1'b0, 32'h0, 1'b0);
	ex_m = '0;
	dc_m = '0;
	repeat (2) @(posedge clk);
	@(negedge clk);
	rst = 1'b0;

	sample();                                         // Both slots invalid.
	check_value("stall_req", stall_req, 1'b1);
	advance();
	drive(1'b1, enc(K_ADDU, 1, 2, 3), 1'b1, enc(K_ADDU, 1, 2, 1), 1'b0);
	sample();
	check_value("issue_num", issue_num, 2'd2);
	check_value("stall_req", stall_req, 1'b0);
	advance();
	finish_test(1, "after reset");

	for (int r = 0; r < 9; r++) begin
		case (r)
			0: drive(1'b1, enc(K_ADDU, 1, 2, 3), 1'b1, enc(K_ADDU, 3, 1, 2), 1'b0);
			1: drive(1'b1, enc(K_LW, 1, 2, 0), 1'b1, enc(K_SW, 1, 3, 0), 1'b0);
			2: drive(1'b1, enc(K_MULT, 1, 3, 0), 1'b1, enc(K_MFHI, 0, 0, 3), 1'b0);
			3: drive(1'b1, enc(K_SSNOP, 0, 0, 0), 1'b1, enc(K_ADDU, 1, 2, 3), 1'b0);
			4: drive(1'b1, enc(K_ADDU, 1, 1, 3), 1'b1, enc(K_SC, 2, 2, 0), 1'b0);
			5: drive(1'b1, enc(K_ADDU, 1, 1, 3), 1'b1, enc(K_MFC0, 0, 2, 1), 1'b0);
			6: drive(1'b1, enc(K_ADDU, 1, 1, 2), 1'b1, enc(K_ADDU, 1, 1, 3), 1'b1);
			7: drive(1'b1, enc(K_ADDU, 1, 1, 2), 1'b0, enc(K_ADDU, 1, 1, 3), 1'b0);
			default: drive(1'b1, enc(K_ADDU, 1, 1, 2), 1'b1, enc(K_ADDU, 3, 3, 1), 1'b0);
		endcase
		sample();
		check_value("issue_num", issue_num, (r == 8) ? 2'd2 : 2'd1);
		if (r < 8)
			check_value("issue_instr[1]", issue_instr[1], '0);
		advance();
	end
	finish_test(2, "pair rules");

	flush();
	drive(1'b1, enc(K_LW, 1, 2, 0), 1'b0, 32'h0, 1'b0);
	expect_stalls(0);
	drive(1'b1, enc(K_ADDU, 2, 3, 1), 1'b0, 32'h0, 1'b0);
	expect_stalls(`DCACHE_PIPE_DEPTH);                // Ex and first dcache stage.
	finish_test(3, "load-use stall");

	flush();
	drive(1'b1, enc(K_MFC0, 0, 1, 0), 1'b0, 32'h0, 1'b0);
	expect_stalls(0);
	drive(1'b1, enc(K_ERET, 0, 0, 0), 1'b0, 32'h0, 1'b0);
	expect_stalls(`DCACHE_PIPE_DEPTH + 1);
	drive(1'b1, enc(K_ADDU, 1, 1, 2), 1'b0, 32'h0, 1'b0);
	expect_stalls(`DCACHE_PIPE_DEPTH + 1);
	finish_test(4, "eret");

	flush();
	for (int c = 0; c < RANDOM_CYCLES; c++) begin
		if (!exp_stall || !(fetch_entry[0].valid || fetch_entry[1].valid)) begin
			if (exp_num == 2'd1 && fetch_entry[1].valid)
				drive(1'b1, fetch_entry[1].instr, {$random(seed)} % 8 != 0, rand_instr(),
					{$random(seed)} % 16 == 0);       // Dropped slot 1 moves up.
			else
				drive({$random(seed)} % 8 != 0, rand_instr(), {$random(seed)} % 8 != 0,
					rand_instr(), {$random(seed)} % 16 == 0);
		end
		sample();
		advance();
	end
	finish_test(5, "random run");

	$display("5 tests run, %0d errors", errors);
	if (errors == 0)
		$display("All tests passed!");
	else
		$display("Test failures found");
	$finish;
end

// Watchdog sized from the cycle count of all tests.
initial begin
	#((RANDOM_CYCLES + DIRECTED_CYCLES) * 100 + 10000);
	$display("Timeout: the tests did not finish in the expected time");
	$display("Test failures found");
	$finish;
end

endmodule

// ==== issue_stage.f ====
+incdir+.
cpu_pkg.sv
instr_decoder.sv
instr_issue.sv
exec_pipe_tracker.sv
issue_stage.sv
issue_stage_checker.sv
issue_stage_tb.sv

// ==== Bender.yml ====
package:
  name: issue_stage

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - instr_decoder.sv
      - instr_issue.sv
      - exec_pipe_tracker.sv
      - issue_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - issue_stage_checker.sv
      - issue_stage_tb.sv
